// ==== flist.f ====
source/host_pkg.sv
source/motion_pkg.sv
source/spi_word_port.sv
source/command_decoder.sv
source/move_queue.sv
source/dda_stepper.sv
source/hbridge_sequencer.sv
source/quad_decoder.sv
source/motion_top.sv
dv/tb_clock.sv
dv/motion_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module motion_tb -f flist.f -o motion_sim &&
./obj_dir/motion_sim || exit 1

// ==== dv/motion_tb.sv ====
module motion_tb import host_pkg::*, motion_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic CLK;
  logic arst_n;
  logic sck;
  logic cs_n;
  logic copi;
  logic enc_a;
  logic enc_b;
  logic cipo;
  logic led;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic moving;

  // Model state
  accum_t     m_acc;
  phase_idx_t m_pos;
  logic       m_half;
  logic       m_enable;
  count_t     m_count;
  logic       m_fault;
  logic       m_running;
  int         m_queued;
  logic       m_led;
  logic [1:0] enc_pos;
  logic [31:0] lfsr_state = 32'h1993_431e;

  // Pending comparisons
  string       name_q[$];
  logic [63:0] exp_q[$];
  logic [63:0] act_q[$];

  tb_clock tb_clock_i (.CLK, .arst_n);

  motion_top motion_top_i (
    .CLK, .arst_n, .sck, .cs_n, .copi, .enc_a, .enc_b, .cipo, .led,
    .phase_a1, .phase_a2, .phase_b1, .phase_b2, .moving
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Coil pattern {a1, a2, b1, b2} for a half-step index
  function automatic logic [3:0] phase_bits(input phase_idx_t idx, input logic en);
    logic a_pos;
    logic a_neg;
    logic b_pos;
    logic b_neg;
    a_pos = (idx == 3'd7) || (idx <= 3'd1);
    b_pos = (idx >= 3'd1) && (idx <= 3'd3);
    a_neg = (idx >= 3'd3) && (idx <= 3'd5);
    b_neg = (idx >= 3'd5);
    return en ? {a_pos, a_neg, b_pos, b_neg} : 4'b0000;
  endfunction

  // Second-order DDA over duration+1 ticks
  // Accumulator carried in and out
  function automatic void dda_model(input logic mdir, input duration_t dur, input rate_t inc,
      input rate_t inc_inc, input logic half, inout accum_t acc, inout phase_idx_t pos);
    rate_t      rate;
    phase_idx_t stride;
    stride = half ? 3'd1 : 3'd2;
    for (duration_t t = '0; t <= dur; t++) begin
      rate = (t == '0) ? inc : rate + inc_inc;
      acc  = acc + rate;
      if (acc > 64'sd0) begin
        acc = acc - STEP_THRESHOLD;
        pos = mdir ? pos + stride : pos - stride;
      end
    end
  endfunction

  task automatic fail_run();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      fail_run();
    end
  endtask

  function automatic void expect_value(input string name, input logic [63:0] exp,
      input logic [63:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endfunction

  // Compares one queued sample per cycle
  always @(posedge CLK) begin
    if (act_q.size() != 0) begin
      check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end
  end

  // Mode 0 frame with 4 CLK per SCK half period
  // Reply bit sampled just before each rise
  task automatic spi_frame(input word_t tx, output word_t rx);
    word_t got;
    got = '0;
    @(posedge CLK);
    cs_n <= 1'b0;
    repeat (4) @(posedge CLK);
    for (int i = 63; i >= 0; i--) begin
      copi <= tx[i];
      repeat (4) @(posedge CLK);
      got = {got[62:0], cipo};
      sck <= 1'b1;
      repeat (4) @(posedge CLK);
      sck <= 1'b0;
    end
    repeat (4) @(posedge CLK);
    cs_n <= 1'b1;
    // Gap lets the word land before the next frame
    repeat (8) @(posedge CLK);
    // Heartbeat flips once per received word
    m_led = ~m_led;
    expect_value("led heartbeat", 64'(m_led), 64'(led));
    rx = got;
  endtask

  task automatic send_config(input opcode_t op, input logic [7:0] value);
    word_t rx;
    spi_frame({op, 48'd0, value}, rx);
  endtask

  // Header, duration, increment, increment-increment
  task automatic send_random_move(input logic mdir, input int min_ticks);
    duration_t dur;
    rate_t     inc;
    rate_t     inc_inc;
    word_t     rx;
    dur     = duration_t'(min_ticks) + rand_bits(4);
    inc     = rate_t'(64'h0800_0000_0000_0000 + rand_bits(58));
    inc_inc = rate_t'(rand_bits(54) - 64'h0020_0000_0000_0000);
    spi_frame({CMD_COORDINATED_STEP, 55'd0, mdir}, rx);
    spi_frame(word_t'(dur), rx);
    spi_frame(word_t'(inc), rx);
    spi_frame(word_t'(inc_inc), rx);
    // Idle stepper takes it at once and a busy one needs a free slot
    if (!m_running) begin
      m_running = 1'b1;
      dda_model(mdir, dur, inc, inc_inc, m_half, m_acc, m_pos);
    end else if (m_queued < MOVE_DEPTH) begin
      m_queued++;
      dda_model(mdir, dur, inc, inc_inc, m_half, m_acc, m_pos);
    end
  endtask

  // Status arrives in the frame after the version header
  task automatic check_status(input string name);
    word_t rx;
    word_t expected;
    spi_frame({CMD_API_VERSION, 56'd0}, rx);
    spi_frame('0, rx);
    expected = {31'd0, m_fault, 8'(MOVE_DEPTH - m_queued),
                VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
    expect_value(name, expected, rx);
  endtask

  task automatic check_count(input string name);
    word_t rx;
    spi_frame('0, rx);
    expect_value(name, m_count, rx);
  endtask

  function automatic void check_phases(input string name);
    expect_value(name, 64'(phase_bits(m_pos, m_enable)),
                 64'({phase_a1, phase_a2, phase_b1, phase_b2}));
  endfunction

  // delta of +1 forward, -1 reverse, +2 both lines at once
  task automatic encoder_steps(input int nsteps, input int delta);
    for (int n = 0; n < nsteps; n++) begin
      enc_pos = enc_pos + 2'(delta);
      @(posedge CLK);
      enc_a <= enc_pos[1];
      enc_b <= enc_pos[1] ^ enc_pos[0];
      repeat (4) @(posedge CLK);
      if (delta == 1) begin
        m_count = m_count + 64'sd1;
      end else if (delta == -1) begin
        m_count = m_count - 64'sd1;
      end else begin
        m_fault = 1'b1;
      end
    end
  endtask

  // Idle means moving low for 8 cycles in a row
  task automatic wait_idle(input int limit);
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    while (quiet < 8 && cycles < limit) begin
      @(posedge CLK);
      cycles++;
      quiet = moving ? 0 : quiet + 1;
    end
    if (quiet < 8) begin
      $display("Timeout: moving still high after %0d cycles", limit);
      fail_run();
    end
    m_running = 1'b0;
    m_queued  = 0;
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (arst_n !== 1'b1 && cycles < 50) begin
      @(posedge CLK);
      cycles++;
    end
    if (arst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      fail_run();
    end
  endtask

  task automatic drain_checks();
    int cycles;
    cycles = 0;
    while (act_q.size() != 0 && cycles < 100) begin
      @(posedge CLK);
      cycles++;
    end
    if (act_q.size() != 0) begin
      $display("Timeout: comparisons left unprocessed");
      fail_run();
    end
  endtask

  initial begin
    int   n_fwd;
    int   n_rev;
    logic mdir;
    sck       <= 1'b0;
    cs_n      <= 1'b1;
    copi      <= 1'b0;
    enc_a     <= 1'b0;
    enc_b     <= 1'b0;
    m_acc     = '0;
    m_pos     = '0;
    m_half    = 1'b0;
    m_enable  = 1'b0;
    m_count   = '0;
    m_fault   = 1'b0;
    m_running = 1'b0;
    m_queued  = 0;
    m_led     = 1'b0;
    enc_pos   = '0;
    wait_reset();
    repeat (4) @(posedge CLK);

    // Status after reset
    expect_value("reset moving", 64'd0, 64'(moving));
    check_phases("reset phases");
    check_status("reset status");

    // Encoder counting and then an illegal jump
    n_fwd = 1 + int'(rand_bits(5));
    n_rev = int'(rand_bits(4));
    encoder_steps(n_fwd, 1);
    encoder_steps(n_rev, -1);
    check_count("encoder count");
    encoder_steps(1, 2);
    check_count("count after fault");
    check_status("fault status");

    // Two opposite moves in full step at the default divisor
    send_config(CMD_MOTOR_ENABLE, 8'd1);
    m_enable = 1'b1;
    mdir = rand_bits(1) != '0;
    send_random_move(mdir, 4);
    wait_idle(100000);
    check_phases("first move phases");
    send_random_move(!mdir, 4);
    wait_idle(100000);
    check_phases("reverse move phases");

    // Half step with a short divisor
    send_config(CMD_MICROSTEPS, 8'd1);
    m_half = 1'b1;
    send_config(CMD_CLK_DIVISOR, 8'(5 + rand_bits(3)));
    send_random_move(rand_bits(1) != '0, 4);
    wait_idle(100000);
    check_phases("half step phases");
    send_config(CMD_MOTOR_ENABLE, 8'd0);
    m_enable = 1'b0;
    check_phases("disabled phases");
    send_config(CMD_MOTOR_ENABLE, 8'd1);
    m_enable = 1'b1;
    check_phases("re-enabled phases");

    // Leading move holds the stepper while the burst fills the queue
    send_config(CMD_CLK_DIVISOR, 8'd255);
    send_random_move(rand_bits(1) != '0, 63);
    for (int k = 0; k <= MOVE_DEPTH; k++) begin
      send_random_move(rand_bits(1) != '0, 16);
    end
    check_status("credits during burst");
    wait_idle(400000);
    check_phases("burst phases");
    check_status("credits after burst");

    drain_checks();
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock (
  output logic CLK,
  output logic arst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  // Free running, 10 ns period
  initial begin
    CLK = 1'b0;
    forever begin
      #5 CLK = ~CLK;
    end
  end

  // Reset held low over the first 3 rising edges
  initial begin
    arst_n <= 1'b0;
    repeat (3) @(posedge CLK);
    arst_n <= 1'b1;
  end

endmodule

// ==== source/motion_top.sv ====
module motion_top import host_pkg::*, motion_pkg::*; (
  input  logic CLK,
  input  logic arst_n,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  input  logic enc_a,
  input  logic enc_b,
  output logic cipo,
  output logic led,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic moving
);

  // Host side
  word_t     rx_word;
  word_t     reply_word;
  logic      word_valid;
  count_t    encoder_count;
  logic      encoder_fault;

  // Config and moves from the decoder
  logic      motor_enable;
  divisor_t  clk_divisor;
  ustep_t    microstep;
  logic      move_push;
  logic      move_dir;
  duration_t move_duration;
  rate_t     move_increment;
  rate_t     move_inc_inc;
  logic      credit_return;

  // Queue head and stepper
  logic      move_valid;
  logic      move_pop;
  logic      head_dir;
  duration_t head_duration;
  rate_t     head_increment;
  rate_t     head_inc_inc;
  logic      step;
  logic      dir;

  spi_word_port spi_word_port_i (
    .CLK, .arst_n, .sck, .cs_n, .copi, .cipo, .reply_word, .rx_word, .word_valid
  );

  command_decoder command_decoder_i (
    .CLK, .arst_n, .rx_word, .word_valid, .encoder_count, .encoder_fault,
    .credit_return, .reply_word, .led, .motor_enable, .clk_divisor, .microstep,
    .move_push, .move_dir, .move_duration, .move_increment, .move_inc_inc
  );

  move_queue move_queue_i (
    .CLK, .arst_n, .move_push, .move_dir, .move_duration, .move_increment,
    .move_inc_inc, .move_pop, .move_valid, .head_dir, .head_duration,
    .head_increment, .head_inc_inc, .credit_return
  );

  dda_stepper dda_stepper_i (
    .CLK, .arst_n, .move_valid, .head_dir, .head_duration, .head_increment,
    .head_inc_inc, .clk_divisor, .move_pop, .step, .dir, .moving
  );

  hbridge_sequencer hbridge_sequencer_i (
    .CLK, .arst_n, .step, .dir, .microstep, .motor_enable,
    .phase_a1, .phase_a2, .phase_b1, .phase_b2
  );

  quad_decoder quad_decoder_i (
    .CLK, .arst_n, .enc_a, .enc_b, .count(encoder_count), .fault(encoder_fault)
  );

endmodule

// ==== source/quad_decoder.sv ====
module quad_decoder import motion_pkg::*; (
  input  logic   CLK,
  input  logic   arst_n,
  input  logic   enc_a,
  input  logic   enc_b,
  output count_t count,
  output logic   fault
);

  logic [1:0] a_q;
  logic [1:0] b_q;
  logic [1:0] prev_ab;
  logic [1:0] cur_ab;

  // Synchronized state as {a, b}
  assign cur_ab = {a_q[1], b_q[1]};

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      a_q     <= '0;
      b_q     <= '0;
      prev_ab <= '0;
      count   <= '0;
      fault   <= 1'b0;
    end else begin
      a_q     <= {a_q[0], enc_a};
      b_q     <= {b_q[0], enc_b};
      prev_ab <= cur_ab;
      case ({prev_ab, cur_ab})
        // Forward 00 -> 01 -> 11 -> 10
        4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: count <= count + 64'sd1;
        // Reverse
        4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: count <= count - 64'sd1;
        // Both lines moved, position lost
        4'b00_11, 4'b11_00, 4'b01_10, 4'b10_01: fault <= 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== source/hbridge_sequencer.sv ====
module hbridge_sequencer import motion_pkg::*; (
  input  logic   CLK,
  input  logic   arst_n,
  input  logic   step,
  input  logic   dir,
  input  ustep_t microstep,
  input  logic   motor_enable,
  output logic   phase_a1,
  output logic   phase_a2,
  output logic   phase_b1,
  output logic   phase_b2
);

  phase_idx_t  pos;
  phase_idx_t  stride;
  phase_bits_t drive;

  // Full step skips the two-coil entries
  assign stride = (microstep == USTEP_HALF) ? 3'd1 : 3'd2;

  // Position tracks steps even with the bridge off
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pos <= '0;
    end else if (step) begin
      if (dir) begin
        pos <= pos + stride;
      end else begin
        pos <= pos - stride;
      end
    end
  end

  // Bridge released when disabled
  assign drive = motor_enable ? PHASE_TABLE[pos] : '0;

  assign {phase_a1, phase_a2, phase_b1, phase_b2} = drive;

endmodule

// ==== source/dda_stepper.sv ====
module dda_stepper import motion_pkg::*; (
  input  logic      CLK,
  input  logic      arst_n,
  input  logic      move_valid,
  input  logic      head_dir,
  input  duration_t head_duration,
  input  rate_t     head_increment,
  input  rate_t     head_inc_inc,
  input  divisor_t  clk_divisor,
  output logic      move_pop,
  output logic      step,
  output logic      dir,
  output logic      moving
);

  divisor_t  div_cnt;
  logic      tick;
  logic      first_tick;
  duration_t ticks_left;
  rate_t     inc;
  rate_t     inc_inc;
  rate_t     rate;
  rate_t     rate_next;
  accum_t    accum;
  accum_t    accum_sum;

  // Take the head only between moves
  assign move_pop = !moving && move_valid;

  // One DDA tick every clk_divisor cycles
  assign tick = moving && (div_cnt == clk_divisor - 8'd1);

  // Rate ramps linearly after the first tick
  assign rate_next = first_tick ? inc : rate + inc_inc;
  assign accum_sum = accum + rate_next;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      moving     <= 1'b0;
      step       <= 1'b0;
      dir        <= 1'b0;
      div_cnt    <= '0;
      first_tick <= 1'b0;
      accum      <= '0;
    end else begin
      step <= 1'b0;
      if (move_pop) begin
        moving     <= 1'b1;
        dir        <= head_dir;
        div_cnt    <= '0;
        first_tick <= 1'b1;
      end else if (tick) begin
        div_cnt    <= '0;
        first_tick <= 1'b0;
        // Positive accumulator means one step is due
        if (accum_sum > 0) begin
          step  <= 1'b1;
          accum <= accum_sum - STEP_THRESHOLD;
        end else begin
          accum <= accum_sum;
        end
        // tick at zero count is the last one
        if (ticks_left == '0) begin
          moving <= 1'b0;
        end
      end else if (moving) begin
        div_cnt <= div_cnt + 8'd1;
      end
    end
  end

  // Move parameters and running rate
  always_ff @(posedge CLK) begin
    if (move_pop) begin
      ticks_left <= head_duration;
      inc        <= head_increment;
      inc_inc    <= head_inc_inc;
    end else if (tick) begin
      ticks_left <= ticks_left - 64'd1;
      rate       <= rate_next;
    end
  end

endmodule

// ==== source/move_queue.sv ====
module move_queue import motion_pkg::*; (
  input  logic      CLK,
  input  logic      arst_n,
  input  logic      move_push,
  input  logic      move_dir,
  input  duration_t move_duration,
  input  rate_t     move_increment,
  input  rate_t     move_inc_inc,
  input  logic      move_pop,
  output logic      move_valid,
  output logic      head_dir,
  output duration_t head_duration,
  output rate_t     head_increment,
  output rate_t     head_inc_inc,
  output logic      credit_return
);

  // One slot per credit
  logic      dir_mem     [MOVE_DEPTH];
  duration_t dur_mem     [MOVE_DEPTH];
  rate_t     inc_mem     [MOVE_DEPTH];
  rate_t     inc_inc_mem [MOVE_DEPTH];
  qptr_t     wr_ptr;
  qptr_t     rd_ptr;
  credit_t   fill;
  logic      do_pop;

  assign move_valid = (fill != '0);
  assign do_pop     = move_pop && move_valid;

  always_ff @(posedge CLK) begin
    if (move_push) begin
      dir_mem[wr_ptr]     <= move_dir;
      dur_mem[wr_ptr]     <= move_duration;
      inc_mem[wr_ptr]     <= move_increment;
      inc_inc_mem[wr_ptr] <= move_inc_inc;
    end
  end

  // Pointers wrap on their own width
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill          <= '0;
      credit_return <= 1'b0;
    end else begin
      wr_ptr        <= wr_ptr + qptr_t'(move_push);
      rd_ptr        <= rd_ptr + qptr_t'(do_pop);
      fill          <= fill + credit_t'(move_push) - credit_t'(do_pop);
      // Freed slot goes back to the decoder
      credit_return <= do_pop;
    end
  end

  // Head stays put until popped
  assign head_dir       = dir_mem[rd_ptr];
  assign head_duration  = dur_mem[rd_ptr];
  assign head_increment = inc_mem[rd_ptr];
  assign head_inc_inc   = inc_inc_mem[rd_ptr];

endmodule

// ==== source/command_decoder.sv ====
module command_decoder import host_pkg::*, motion_pkg::*; (
  input  logic      CLK,
  input  logic      arst_n,
  input  word_t     rx_word,
  input  logic      word_valid,
  input  count_t    encoder_count,
  input  logic      encoder_fault,
  input  logic      credit_return,
  output word_t     reply_word,
  output logic      led,
  output logic      motor_enable,
  output divisor_t  clk_divisor,
  output ustep_t    microstep,
  output logic      move_push,
  output logic      move_dir,
  output duration_t move_duration,
  output rate_t     move_increment,
  output rate_t     move_inc_inc
);

  decoder_state_t state;
  opcode_t        opcode;
  opcode_t        rx_opcode;
  logic [1:0]     data_cnt;
  logic           move_word;
  logic           credit_take;
  credit_t        credits;
  logic           status_sel;
  word_t          status_word;

  assign rx_opcode = rx_word[63:56];

  // Data word belonging to a coordinated move
  assign move_word = word_valid && (state == DATA) && (opcode == CMD_COORDINATED_STEP);

  // Third data word finishes the move, pushed only with a credit in hand
  assign credit_take = move_word && (data_cnt == 2'd2) && (credits != '0);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state        <= HEADER;
      opcode       <= '0;
      data_cnt     <= '0;
      led          <= 1'b0;
      motor_enable <= 1'b0;
      clk_divisor  <= DIVISOR_RESET;
      microstep    <= USTEP_FULL;
      status_sel   <= 1'b0;
      move_push    <= 1'b0;
    end else begin
      move_push <= credit_take;
      if (word_valid) begin
        // Heartbeat on every word
        led        <= ~led;
        status_sel <= 1'b0;
        if (state == HEADER) begin
          opcode   <= rx_opcode;
          data_cnt <= '0;
          // Config commands act on the header itself
          case (rx_opcode)
            CMD_MOTOR_ENABLE: motor_enable <= rx_word[0];
            CMD_CLK_DIVISOR:  clk_divisor <= rx_word[7:0];
            CMD_MICROSTEPS:   microstep <= rx_word[0];
            CMD_API_VERSION: begin
              // Status goes out in the next frame
              status_sel <= 1'b1;
              state      <= DATA;
            end
            CMD_COORDINATED_STEP: state <= DATA;
            default: ;
          endcase
        end else begin
          data_cnt <= data_cnt + 2'd1;
          // Version query has a single dummy word
          if (opcode != CMD_COORDINATED_STEP || data_cnt == 2'd2) begin
            state <= HEADER;
          end
        end
      end
    end
  end

  // Move fields, direction rides in the header LSB
  always_ff @(posedge CLK) begin
    if (word_valid && state == HEADER && rx_opcode == CMD_COORDINATED_STEP) begin
      move_dir <= rx_word[0];
    end
    if (move_word) begin
      case (data_cnt)
        2'd0:    move_duration <= duration_t'(rx_word);
        2'd1:    move_increment <= rate_t'(rx_word);
        2'd2:    move_inc_inc <= rate_t'(rx_word);
        default: ;
      endcase
    end
  end

  // One credit per queue slot, back when the stepper pops
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      credits <= credit_t'(MOVE_DEPTH);
    end else begin
      credits <= credits + credit_t'(credit_return) - credit_t'(credit_take);
    end
  end

  // Status reply with live credit and fault
  always_comb begin
    status_word = '0;
    status_word[REPLY_PATCH_LSB +: 8]  = VERSION_PATCH;
    status_word[REPLY_MINOR_LSB +: 8]  = VERSION_MINOR;
    status_word[REPLY_MAJOR_LSB +: 8]  = VERSION_MAJOR;
    status_word[REPLY_CREDIT_LSB +: 8] = 8'(credits);
    status_word[REPLY_FAULT_BIT]       = encoder_fault;
  end

  // Encoder position unless a version query is pending
  assign reply_word = status_sel ? status_word : word_t'(encoder_count);

endmodule

// ==== source/spi_word_port.sv ====
module spi_word_port import host_pkg::*; (
  input  logic  CLK,
  input  logic  arst_n,
  input  logic  sck,
  input  logic  cs_n,
  input  logic  copi,
  output logic  cipo,
  input  word_t reply_word,
  output word_t rx_word,
  output logic  word_valid
);

  // Two sync stages, third stage only for edge detect
  logic [2:0] sck_q;
  logic [2:0] cs_q;
  logic [1:0] copi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_fall;
  logic       cs_idle;
  logic [5:0] bit_cnt;
  word_t      rx_shift;
  word_t      tx_shift;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sck_q  <= '0;
      cs_q   <= '1;
      copi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs_n};
      copi_q <= {copi_q[0], copi};
    end
  end

  // Edges seen on the synchronized copies
  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign cs_fall  = ~cs_q[1] & cs_q[2];
  assign cs_idle  = cs_q[1];

  // Bit count, cleared whenever the host deselects
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt    <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (cs_idle) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 6'd1;
        // 64th rise completes the word
        if (bit_cnt == 6'd63) begin
          word_valid <= 1'b1;
        end
      end
    end
  end

  // Mode 0: sample on rise, shift out on fall
  always_ff @(posedge CLK) begin
    if (!cs_idle && sck_rise) begin
      rx_shift <= {rx_shift[62:0], copi_q[1]};
    end
    if (cs_fall) begin
      tx_shift <= reply_word;
    end else if (!cs_idle && sck_fall) begin
      tx_shift <= {tx_shift[62:0], 1'b0};
    end
  end

  // Whole word sits in the shifter while word_valid is high
  assign rx_word = rx_shift;
  assign cipo    = tx_shift[63];

endmodule

// ==== source/motion_pkg.sv ====
package motion_pkg;

  // Move fields as carried by the host words
  typedef logic [63:0]        duration_t;
  typedef logic signed [63:0] rate_t;
  typedef logic signed [63:0] accum_t;

  // Encoder position, x4 counts
  typedef logic signed [63:0] count_t;

  // CLK cycles per DDA tick
  typedef logic [7:0] divisor_t;
  localparam divisor_t DIVISOR_RESET = 8'd40;

  // Microstep mode
  typedef logic ustep_t;
  localparam ustep_t USTEP_FULL = 1'b0;
  localparam ustep_t USTEP_HALF = 1'b1;

  // Move queue, depth must be a power of two
  localparam int MOVE_DEPTH = 4;
  localparam int QPTR_W     = $clog2(MOVE_DEPTH);
  typedef logic [QPTR_W-1:0] qptr_t;
  typedef logic [2:0]        credit_t;

  // Taken off the accumulator on every step
  localparam accum_t STEP_THRESHOLD = 64'sh7fffffffffffff9b;

  // Half-step table, bits are {a1, a2, b1, b2}
  typedef logic [2:0] phase_idx_t;
  typedef logic [3:0] phase_bits_t;
  localparam phase_bits_t [0:7] PHASE_TABLE = '{
    4'b1000, 4'b1010, 4'b0010, 4'b0110,
    4'b0100, 4'b0101, 4'b0001, 4'b1001
  };

endpackage

// ==== source/host_pkg.sv ====
package host_pkg;

  // One full SPI frame, MSB first
  typedef logic [63:0] word_t;

  // Command byte, top byte of a header word
  typedef logic [7:0] opcode_t;

  // Header opcodes
  localparam opcode_t CMD_MOTOR_ENABLE     = 8'h01;
  localparam opcode_t CMD_CLK_DIVISOR      = 8'h02;
  localparam opcode_t CMD_MICROSTEPS       = 8'h03;
  localparam opcode_t CMD_API_VERSION      = 8'h04;
  localparam opcode_t CMD_COORDINATED_STEP = 8'h05;

  // Reported API version
  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd1;

  // Status reply layout, everything else reads zero
  localparam int REPLY_PATCH_LSB  = 0;
  localparam int REPLY_MINOR_LSB  = 8;
  localparam int REPLY_MAJOR_LSB  = 16;
  localparam int REPLY_CREDIT_LSB = 24;
  localparam int REPLY_FAULT_BIT  = 32;

  // Word decoder: expecting a header or trailing data words
  typedef enum logic {
    HEADER,
    DATA
  } decoder_state_t;

endpackage
